/* source/isa_consts.svh */
`ifndef ISA_CONSTS_SVH
`define ISA_CONSTS_SVH

// Width of a register value, a PC and an effective address.
`define XLEN 32

// Width of the instruction word as fetched.
`define INST_BITS 32

// Reorder buffer holds 32 entries.
`define ROB_TAG_BITS 5

// One enable bit per byte lane of the data bus.
`define BYTE_EN_BITS (`XLEN / 8)

// Number of address bits that select a byte inside a word.
`define LANE_OFFSET_BITS 2

// Debug patterns for an illegal operand select.
// They are easy to spot in a waveform or a memory dump.
`define OPA_FALLBACK 32'hdeadface
`define OPB_FALLBACK 32'hfacefeed

// Masks for the aligned access widths, before the lane shift.
`define BYTE_MASK 4'b0001
`define HALF_MASK 4'b0011
`define WORD_MASK 4'b1111

`endif

/* source/fu_pkg.sv */
`default_nettype none

`include "isa_consts.svh"

package fu_pkg;

    typedef logic [`XLEN-1:0] data_t;

    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_npc  = 2'h1,
        opa_is_pc   = 2'h2,
        opa_is_zero = 2'h3
    } opa_sel_t;

    // Codes 6 and 7 are illegal.
    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } opb_sel_t;

    typedef enum logic [1:0] {
        size_byte = 2'h0,
        size_half = 2'h1,
        size_word = 2'h2 // Code 3 is illegal.
    } mem_size_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_form_t;

    // Also the B layout, with the immediate bits scrambled.
    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_form_t;

    typedef union packed {
        i_form_t i_form;
        s_form_t s_form;
    } inst_word_t;

    typedef struct packed {
        data_t                    pc;
        data_t                    npc;
        inst_word_t               inst;
        opa_sel_t                 opa_select;
        opb_sel_t                 opb_select;
        mem_size_t                mem_size;
        logic                     is_store;
        logic                     is_unsigned;
        logic [`ROB_TAG_BITS-1:0] rob_tag;
    } decoded_t;

    typedef struct packed {
        decoded_t decoded;
        data_t    rs1_value;
        data_t    rs2_value;
    } issue_packet_t;

    typedef struct packed {
        decoded_t decoded;
        data_t    alu_result;
        data_t    store_value; // The rs2 value, kept for the store.
    } fu_packet_t;

    typedef struct packed {
        data_t                    address;
        logic [`BYTE_EN_BITS-1:0] byte_en;
        logic                     misaligned;
        logic                     is_store;
        logic                     is_unsigned;
        data_t                    store_data;
        logic [`ROB_TAG_BITS-1:0] rob_tag;
    } mem_req_t;

endpackage

`default_nettype wire

/* source/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module operand_select (
    input  fu_pkg::issue_packet_t is_pack,
    output fu_pkg::data_t         result
);
    import fu_pkg::*;

    decoded_t            dec;
    logic [`INST_BITS-1:0] inst_raw;
    data_t               opa;
    data_t               opb;
    data_t               i_imm;
    data_t               s_imm;
    data_t               b_imm;
    data_t               u_imm;
    data_t               j_imm;

    assign dec      = is_pack.decoded;
    assign inst_raw = dec.inst;

    assign i_imm = {{20{dec.inst.i_form.imm_11_0[11]}}, dec.inst.i_form.imm_11_0};
    assign s_imm = {{20{dec.inst.s_form.imm_11_5[6]}},
                    dec.inst.s_form.imm_11_5,
                    dec.inst.s_form.imm_4_0};

    // Bit 7 holds imm[11] and bit 31 the sign for branches.
    assign b_imm = {{20{inst_raw[31]}},
                    inst_raw[7],
                    dec.inst.s_form.imm_11_5[5:0],
                    dec.inst.s_form.imm_4_0[4:1],
                    1'b0};

    assign u_imm = {inst_raw[31:12], 12'h000};
    assign j_imm = {{12{inst_raw[31]}},
                    inst_raw[19:12],
                    inst_raw[20],
                    inst_raw[30:21],
                    1'b0};

    always_comb begin
        case (dec.opa_select)
            opa_is_rs1:  opa = is_pack.rs1_value;
            opa_is_npc:  opa = dec.npc;
            opa_is_pc:   opa = dec.pc;
            opa_is_zero: opa = '0;
            default:     opa = `OPA_FALLBACK;
        endcase
    end

    always_comb begin
        case (dec.opb_select)
            opb_is_rs2:   opb = is_pack.rs2_value;
            opb_is_i_imm: opb = i_imm;
            opb_is_s_imm: opb = s_imm;
            opb_is_b_imm: opb = b_imm;
            opb_is_u_imm: opb = u_imm;
            opb_is_j_imm: opb = j_imm;
            default:      opb = `OPB_FALLBACK;
        endcase
    end

    // Carry out is dropped, so the sum wraps modulo 2^32.
    assign result = opa + opb;

endmodule

`default_nettype wire

/* source/addr_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_calc (
    input  logic                  clock,
    input  logic                  reset,
    input  fu_pkg::issue_packet_t is_pack,
    input  logic                  stall,
    input  logic                  rd_in,
    output fu_pkg::fu_packet_t    fu_out,
    output logic                  data_ready
);
    import fu_pkg::*;

    fu_packet_t out_packet;
    fu_packet_t next_packet;
    data_t      alu_result;

    operand_select u_operand_select (
        .is_pack (is_pack),
        .result  (alu_result)
    );

    always_comb begin
        next_packet.decoded     = is_pack.decoded;
        next_packet.alu_result  = alu_result;
        next_packet.store_value = is_pack.rs2_value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            out_packet <= '0;
            data_ready <= 1'b0;
        end else if (stall) begin
            out_packet <= out_packet; // Hold for the stalled consumer.
            data_ready <= data_ready;
        end else if (rd_in) begin
            out_packet <= next_packet;
            data_ready <= 1'b1;
        end else begin
            // No issue this cycle, so a bubble moves down the pipe.
            out_packet <= '0;
            data_ready <= 1'b0;
        end
    end

    assign fu_out = out_packet;

endmodule

`default_nettype wire

/* source/mem_access_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module mem_access_decode (
    input  fu_pkg::fu_packet_t fu_in,
    input  logic               data_ready,
    output fu_pkg::mem_req_t   mem_req
);
    import fu_pkg::*;

    logic [`LANE_OFFSET_BITS-1:0] offset;
    logic [`BYTE_EN_BITS-1:0]     byte_en;
    logic                         misaligned;
    data_t                        store_data;

    assign offset = fu_in.alu_result[`LANE_OFFSET_BITS-1:0];

    // A bubble would otherwise decode as a byte access at address 0.
    always_comb begin
        if (!data_ready) begin
            byte_en = '0;
        end else begin
            case (fu_in.decoded.mem_size)
                size_byte: byte_en = `BYTE_MASK << offset;
                size_half: byte_en = `HALF_MASK << offset; // Upper lanes fall off the end.
                size_word: byte_en = `WORD_MASK;
                default:   byte_en = '0;
            endcase
        end
    end

    always_comb begin
        misaligned = 1'b0;
        if (data_ready) begin
            case (fu_in.decoded.mem_size)
                size_half: misaligned = offset[0];
                size_word: misaligned = (offset != '0);
                default:   misaligned = 1'b0;
            endcase
        end
    end

    // Move the store value into the byte lane picked by the address.
    assign store_data = fu_in.decoded.is_store ? (fu_in.store_value << {offset, 3'b000}) : '0;

    always_comb begin
        mem_req.address     = fu_in.alu_result;
        mem_req.byte_en     = byte_en;
        mem_req.misaligned  = misaligned;
        mem_req.is_store    = fu_in.decoded.is_store;
        mem_req.is_unsigned = fu_in.decoded.is_unsigned;
        mem_req.store_data  = store_data;
        mem_req.rob_tag     = fu_in.decoded.rob_tag;
    end

endmodule

`default_nettype wire

/* source/addr_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_unit_top (
    input  logic                  clock,
    input  logic                  reset,
    input  fu_pkg::issue_packet_t is_pack,
    input  logic                  stall,
    input  logic                  rd_in,
    output fu_pkg::mem_req_t      mem_req,
    output logic                  data_ready
);
    import fu_pkg::*;

    fu_packet_t fu_out;
    logic       ready;

    addr_calc u_addr_calc (
        .clock      (clock),
        .reset      (reset),
        .is_pack    (is_pack),
        .stall      (stall),
        .rd_in      (rd_in),
        .fu_out     (fu_out),
        .data_ready (ready)
    );

    // The decoder needs the ready level to mask bubbles.
    mem_access_decode u_mem_access_decode (
        .fu_in      (fu_out),
        .data_ready (ready),
        .mem_req    (mem_req)
    );

    assign data_ready = ready;

endmodule

`default_nettype wire

/* dv/addr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "isa_consts.svh"

module addr_unit_tb;
    import fu_pkg::*;

    localparam int MAX_RECORDS  = 64;
    localparam int CLOCK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam     STIMULUS_FILE = "dv/addr_unit_stimulus.txt";

    logic          clock;
    logic          reset;
    issue_packet_t is_pack;
    logic          stall;
    logic          rd_in;
    mem_req_t      mem_req;
    logic          data_ready;

    string       rec_name  [MAX_RECORDS];
    data_t       rec_pc    [MAX_RECORDS];
    data_t       rec_inst  [MAX_RECORDS];
    data_t       rec_rs1   [MAX_RECORDS];
    data_t       rec_rs2   [MAX_RECORDS];
    logic [1:0]  rec_opa   [MAX_RECORDS];
    logic [2:0]  rec_opb   [MAX_RECORDS];
    logic [1:0]  rec_size  [MAX_RECORDS];
    logic        rec_store [MAX_RECORDS];
    int          rec_stall [MAX_RECORDS];
    data_t       rec_addr  [MAX_RECORDS];
    logic [3:0]  rec_be    [MAX_RECORDS];
    logic        rec_mis   [MAX_RECORDS];
    data_t       rec_sdata [MAX_RECORDS];

    int          num_records;
    int          max_stall;
    bit          loaded;
    int          check_count;
    int          error_count;
    logic [31:0] rng_state;

    addr_unit_top dut (
        .clock      (clock),
        .reset      (reset),
        .is_pack    (is_pack),
        .stall      (stall),
        .rd_in      (rd_in),
        .mem_req    (mem_req),
        .data_ready (data_ready)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
        error_count++;
    endtask

    task automatic check_req(input string name, input mem_req_t expected,
                             input mem_req_t actual);
        check_count++;
        if (actual.address !== expected.address)
            report_mismatch(name, "address", expected.address, actual.address);
        if (actual.byte_en !== expected.byte_en)
            report_mismatch(name, "byte_en", expected.byte_en, actual.byte_en);
        if (actual.misaligned !== expected.misaligned)
            report_mismatch(name, "misaligned", expected.misaligned, actual.misaligned);
        if (actual.is_store !== expected.is_store)
            report_mismatch(name, "is_store", expected.is_store, actual.is_store);
        if (actual.is_unsigned !== expected.is_unsigned)
            report_mismatch(name, "is_unsigned", expected.is_unsigned, actual.is_unsigned);
        if (actual.store_data !== expected.store_data)
            report_mismatch(name, "store_data", expected.store_data, actual.store_data);
        if (actual.rob_tag !== expected.rob_tag)
            report_mismatch(name, "rob_tag", expected.rob_tag, actual.rob_tag);
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] %s data_ready expected %b actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d mismatches", name, error_count - errors_before);
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          line_no;
        int          fields;
        string       line;
        string       name;
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] addr;
        logic [31:0] sdata;
        int          opa;
        int          opb;
        int          size;
        int          store;
        int          stalls;
        int          mis;
        logic [3:0]  be;
        ok = 1'b1;
        num_records = 0;
        max_stall = 0;
        line_no = 0;
        fd = $fopen(STIMULUS_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s.", STIMULUS_FILE);
            ok = 1'b0;
        end else begin
            while (ok && $fgets(line, fd) != 0) begin
                line_no++;
                // Comment lines start with a hash and blank lines are skipped.
                if (line.len() > 0 && line.getc(0) != 8'h23 && line.getc(0) != 8'h0a &&
                    line.getc(0) != 8'h0d) begin
                    fields = $sscanf(line, "%s %h %h %h %h %d %d %d %d %d %h %b %d %h",
                                     name, pc, inst, rs1, rs2, opa, opb, size, store,
                                     stalls, addr, be, mis, sdata);
                    if (fields != 14) begin
                        $display("Malformed record on line %0d of the stimulus file.",
                                 line_no);
                        ok = 1'b0;
                    end else if (num_records == MAX_RECORDS) begin
                        $display("The stimulus file holds more than %0d records.",
                                 MAX_RECORDS);
                        ok = 1'b0;
                    end else begin
                        rec_name[num_records]  = name;
                        rec_pc[num_records]    = pc;
                        rec_inst[num_records]  = inst;
                        rec_rs1[num_records]   = rs1;
                        rec_rs2[num_records]   = rs2;
                        rec_opa[num_records]   = opa[1:0];
                        rec_opb[num_records]   = opb[2:0];
                        rec_size[num_records]  = size[1:0];
                        rec_store[num_records] = store[0];
                        rec_stall[num_records] = stalls;
                        rec_addr[num_records]  = addr;
                        rec_be[num_records]    = be;
                        rec_mis[num_records]   = mis[0];
                        rec_sdata[num_records] = sdata;
                        if (stalls > max_stall) max_stall = stalls;
                        num_records++;
                    end
                end
            end
            $fclose(fd);
            if (ok && num_records == 0) begin
                $display("The stimulus file holds no records.");
                ok = 1'b0;
            end
        end
    endtask

    task automatic drive_record(input int idx, output issue_packet_t pack);
        rng_state = xorshift32(rng_state);
        pack = '0;
        pack.decoded.pc          = rec_pc[idx];
        pack.decoded.npc         = rec_pc[idx] + 32'd4; // Next sequential instruction.
        pack.decoded.inst        = rec_inst[idx];
        pack.decoded.opa_select  = opa_sel_t'(rec_opa[idx]);
        pack.decoded.opb_select  = opb_sel_t'(rec_opb[idx]);
        pack.decoded.mem_size    = mem_size_t'(rec_size[idx]);
        pack.decoded.is_store    = rec_store[idx];
        pack.decoded.is_unsigned = rng_state[5];
        pack.decoded.rob_tag     = rng_state[`ROB_TAG_BITS-1:0];
        pack.rs1_value           = rec_rs1[idx];
        pack.rs2_value           = rec_rs2[idx];
        is_pack = pack;
        rd_in   = 1'b1;
        stall   = 1'b0;
    endtask

    // Random inputs while stalled. The held result must not see them.
    task automatic drive_noise();
        issue_packet_t pack;
        rng_state = xorshift32(rng_state);
        pack.decoded.pc = rng_state;
        rng_state = xorshift32(rng_state);
        pack.decoded.npc = rng_state;
        rng_state = xorshift32(rng_state);
        pack.decoded.inst = rng_state;
        rng_state = xorshift32(rng_state);
        pack.rs1_value = rng_state;
        rng_state = xorshift32(rng_state);
        pack.rs2_value = rng_state;
        rng_state = xorshift32(rng_state);
        pack.decoded.opa_select  = opa_sel_t'(rng_state[1:0]);
        pack.decoded.opb_select  = opb_sel_t'(rng_state[4:2]);
        pack.decoded.mem_size    = mem_size_t'(rng_state[6:5]);
        pack.decoded.is_store    = rng_state[7];
        pack.decoded.is_unsigned = rng_state[8];
        pack.decoded.rob_tag     = rng_state[13:9];
        is_pack = pack;
        rd_in   = rng_state[14]; // A low rd_in would clear data_ready if the hold failed.
        stall   = 1'b1;
    endtask

    function automatic mem_req_t expected_req(input int idx, input issue_packet_t pack);
        mem_req_t req;
        req.address     = rec_addr[idx];
        req.byte_en     = rec_be[idx];
        req.misaligned  = rec_mis[idx];
        req.is_store    = rec_store[idx];
        req.is_unsigned = pack.decoded.is_unsigned;
        req.store_data  = rec_sdata[idx];
        req.rob_tag     = pack.decoded.rob_tag;
        return req;
    endfunction

    task automatic apply_reset();
        int       cycle;
        int       errors_before;
        mem_req_t zero_req;
        zero_req = '0;
        errors_before = error_count;
        reset = 1'b1;
        for (cycle = 0; cycle < RESET_CYCLES; cycle++) begin
            @(posedge clock);
            #1;
            check_ready("reset", 1'b0, data_ready);
            check_req("reset", zero_req, mem_req);
        end
        reset = 1'b0;
        @(posedge clock);
        #1;
        check_ready("after_reset", 1'b0, data_ready);
        check_req("after_reset", zero_req, mem_req);
        report_test("reset", errors_before);
    endtask

    task automatic run_records();
        int            idx;
        int            k;
        int            errors_before;
        issue_packet_t pack;
        mem_req_t      expected;
        mem_req_t      zero_req;
        zero_req = '0;
        for (idx = 0; idx < num_records; idx++) begin
            errors_before = error_count;
            drive_record(idx, pack);
            expected = expected_req(idx, pack);
            @(posedge clock);
            #1;
            check_ready(rec_name[idx], 1'b1, data_ready);
            check_req(rec_name[idx], expected, mem_req);
            if (rec_stall[idx] > 0) begin
                for (k = 0; k < rec_stall[idx]; k++) begin
                    drive_noise();
                    @(posedge clock);
                    #1;
                    check_ready(rec_name[idx], 1'b1, data_ready);
                    check_req(rec_name[idx], expected, mem_req);
                end
                stall = 1'b0;
                rd_in = 1'b0;
                @(posedge clock);
                #1;
                check_ready({rec_name[idx], "_bubble"}, 1'b0, data_ready);
                check_req({rec_name[idx], "_bubble"}, zero_req, mem_req);
            end
            report_test(rec_name[idx], errors_before);
        end
        errors_before = error_count;
        rd_in = 1'b0;
        stall = 1'b0;
        @(posedge clock);
        #1;
        check_ready("drain", 1'b0, data_ready);
        check_req("drain", zero_req, mem_req);
        report_test("drain", errors_before);
    endtask

    initial begin
        int limit_cycles;
        wait (loaded);
        limit_cycles = num_records * (max_stall + 4) + 32;
        #(limit_cycles * CLOCK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles.", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        bit load_ok;
        reset       = 1'b1;
        stall       = 1'b0;
        rd_in       = 1'b0;
        is_pack     = '0;
        loaded      = 1'b0;
        check_count = 0;
        error_count = 0;
        rng_state   = 32'd77245;
        load_stimulus(load_ok);
        if (!load_ok) begin
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            apply_reset();
            run_records();
            $display("Records: %0d, checks: %0d, errors: %0d", num_records, check_count,
                     error_count);
            if (error_count == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+source
source/fu_pkg.sv
source/operand_select.sv
source/addr_calc.sv
source/mem_access_decode.sv
source/addr_unit_top.sv
dv/addr_unit_tb.sv

/* Bender.yml */
package:
  name: addr_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/fu_pkg.sv
      - source/operand_select.sv
      - source/addr_calc.sv
      - source/mem_access_decode.sv
      - source/addr_unit_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/addr_unit_tb.sv

/* dv/addr_unit_stimulus.txt */
# name pc inst rs1 rs2 opa opb size store stall | address byte_en misaligned store_data
# Selects, size, store, stall and misaligned are decimal, byte_en is binary, the rest hex.
# opa 0 rs1 1 npc 2 pc 3 zero; opb 0 rs2 1 I 2 S 3 B 4 U 5 J; size 0 byte 1 half 2 word.
a_rs1_b_rs2  00001000 00000000 00002000 00000010 0 0 2 0 0 00002010 1111 0 00000000
a_npc_b_rs2  00001000 00000000 00000000 00000100 1 0 2 0 0 00001104 1111 0 00000000
a_pc_b_rs2   00003000 00000000 00000000 00000020 2 0 2 0 2 00003020 1111 0 00000000
a_zero_b_rs2 00000000 00000000 ffffffff 00004008 3 0 2 0 0 00004008 1111 0 00000000
rs2_wrap     00000000 00000000 fffffff0 00000014 0 0 2 0 0 00000004 1111 0 00000000
npc_wrap     fffffffc 00000000 00000000 00000008 1 0 2 0 0 00000008 1111 0 00000000
i_pos        00000000 12300003 00001000 00000000 0 1 0 0 0 00001123 1000 0 00000000
i_neg        00000000 ff800003 00001000 00000000 0 1 1 0 0 00000ff8 0011 0 00000000
i_max_pc     00002000 7ff00003 00000000 00000000 2 1 2 0 1 000027ff 1111 1 00000000
i_minus1_npc 00006000 fff00003 00000000 00000000 1 1 1 0 0 00006003 1000 1 00000000
s_pos        00000000 040002a3 00001000 11223344 0 2 0 1 0 00001045 0010 0 22334400
s_neg        00000000 fe000ea3 00002000 11223344 0 2 1 1 3 00001ffd 0110 1 22334400
s_word       00000000 00000823 00003000 11223344 0 2 2 1 0 00003010 1111 0 11223344
s_max        00000000 7e000fa3 00001000 11223344 0 2 0 1 0 000017ff 1000 0 44000000
s_min        00000000 80000023 00001000 11223344 0 2 2 1 0 00000800 1111 0 11223344
b_pos        00001000 00000863 00000000 00000000 2 3 2 0 0 00001010 1111 0 00000000
b_neg        00001000 fe0008e3 00000000 00000000 2 3 2 0 2 00000ff0 1111 0 00000000
b_bit11      00002000 000000e3 00000000 00000000 2 3 0 0 0 00002800 0001 0 00000000
u_pos        00000000 12345037 00000000 00000000 3 4 2 0 0 12345000 1111 0 00000000
u_neg        00004000 fffff017 00000000 00000000 2 4 2 0 0 00003000 1111 0 00000000
u_rs1        00000000 00001037 00000abc 00000000 0 4 0 0 0 00001abc 0001 0 00000000
j_pos        00001000 1000006f 00000000 00000000 2 5 2 0 0 00001100 1111 0 00000000
j_neg        00001000 ffdff06f 00000000 00000000 2 5 2 0 4 00000ffc 1111 0 00000000
j_npc        00002000 0010006f 00000000 00000000 1 5 2 0 0 00002804 1111 0 00000000
opb_illegal  00000000 00000000 00000000 00000000 3 6 0 0 0 facefeed 0010 0 00000000
byte_off0    00000000 00000023 00005000 11223344 0 2 0 1 0 00005000 0001 0 11223344
byte_off1    00000000 00000023 00005001 11223344 0 2 0 1 0 00005001 0010 0 22334400
byte_off2    00000000 00000023 00005002 11223344 0 2 0 1 0 00005002 0100 0 33440000
byte_off3    00000000 00000023 00005003 11223344 0 2 0 1 0 00005003 1000 0 44000000
half_off0    00000000 00000023 00005100 11223344 0 2 1 1 0 00005100 0011 0 11223344
half_off1    00000000 00000023 00005101 11223344 0 2 1 1 2 00005101 0110 1 22334400
half_off2    00000000 00000023 00005102 11223344 0 2 1 1 0 00005102 1100 0 33440000
half_off3    00000000 00000023 00005103 11223344 0 2 1 1 0 00005103 1000 1 44000000
word_off0    00000000 00000023 00005200 11223344 0 2 2 1 0 00005200 1111 0 11223344
word_off1    00000000 00000023 00005201 11223344 0 2 2 1 0 00005201 1111 1 22334400
word_off2    00000000 00000023 00005202 11223344 0 2 2 1 1 00005202 1111 1 33440000
word_off3    00000000 00000023 00005203 11223344 0 2 2 1 0 00005203 1111 1 44000000
size_illegal 00000000 00000023 00005001 11223344 0 2 3 1 0 00005001 0000 0 22334400
